// File: rtl/arith_pkg.sv
package arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int XLEN = 32;

  // Command entries held in the queue
  localparam int QUEUE_DEPTH = 4;

  // Derived widths for queue pointers and the multiply step counter
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int MUL_CNT_W = $clog2(XLEN);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0] word_t;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_SLT  = 3'd2,
    OP_SLTU = 3'd3,
    OP_MUL  = 3'd4
  } alu_op_e;

  // Execution core states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_MUL  = 2'd1,
    ST_DONE = 2'd2
  } core_state_e;

endpackage

// File: rtl/arith_req_if.sv
`timescale 1ns/1ps

// One queued command on its way from the queue to the core
interface arith_req_if;
  import arith_pkg::*;

  logic    valid;
  logic    ready;
  alu_op_e op;
  word_t   a;
  word_t   b;

  // Queue side
  modport source (
    output valid,
    output op,
    output a,
    output b,
    input  ready
  );

  // Core side
  modport sink (
    input  valid,
    input  op,
    input  a,
    input  b,
    output ready
  );

endinterface

// File: rtl/prefix_adder.sv
`timescale 1ns/1ps

module prefix_adder #(
  parameter int WIDTH = arith_pkg::XLEN
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  // Depth of the up-sweep tree
  localparam int LEVELS = $clog2(WIDTH);

  logic [WIDTH-1:0] p_bit;
  logic [WIDTH-1:0] g_bit;
  logic [WIDTH-1:0] carry;

  // Per-bit propagate and generate
  assign p_bit = a ^ b;
  assign g_bit = a & b;

  ////////////////////////////////////////////////////////////////////////////
  // Up-sweep
  ////////////////////////////////////////////////////////////////////////////

  // Level l combines pairs of groups 2**(l-1) bits apart; the node at the
  // top of every aligned 2**l block ends up holding that block's group
  for (genvar l = 0; l <= LEVELS; l++) begin : up
    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;

    if (l == 0) begin : base
      // Carry in is folded into bit 0, so every group reaching bit 0
      // already accounts for it
      assign g = {g_bit[WIDTH-1:1], g_bit[0] | (p_bit[0] & cin)};
      assign p = p_bit;
    end else begin : level
      for (genvar i = 0; i < WIDTH; i++) begin : bits
        if (((i + 1) % (2 ** l)) == 0) begin : node
          assign g[i] = up[l-1].g[i] | (up[l-1].p[i] & up[l-1].g[i - 2 ** (l - 1)]);
          assign p[i] = up[l-1].p[i] & up[l-1].p[i - 2 ** (l - 1)];
        end else begin : pass
          assign g[i] = up[l-1].g[i];
          assign p[i] = up[l-1].p[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Down-sweep
  ////////////////////////////////////////////////////////////////////////////

  // Fills the prefixes the up-sweep skipped. At level l the node halfway
  // up each 2**l block picks up the finished prefix just below it.
  for (genvar l = LEVELS; l >= 1; l--) begin : dn
    logic [WIDTH-1:0] g;

    if (l == LEVELS) begin : top
      assign g = up[LEVELS].g;
    end else begin : level
      for (genvar i = 0; i < WIDTH; i++) begin : bits
        if ((((i + 1) % (2 ** l)) == 2 ** (l - 1)) && (i >= 2 ** l)) begin : node
          // Upper node still holds its up-sweep group here
          assign g[i] = dn[l+1].g[i] | (up[LEVELS].p[i] & dn[l+1].g[i - 2 ** (l - 1)]);
        end else begin : pass
          assign g[i] = dn[l+1].g[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sum
  ////////////////////////////////////////////////////////////////////////////

  // Carry into bit i is the prefix generate of bits i-1 down to 0
  assign carry = {dn[1].g[WIDTH-2:0], cin};
  assign sum   = p_bit ^ carry;
  assign cout  = dn[1].g[WIDTH-1];

endmodule

// File: rtl/op_queue.sv
`timescale 1ns/1ps

module op_queue (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  arith_pkg::alu_op_e cmd_op,
  input  arith_pkg::word_t   cmd_a,
  input  arith_pkg::word_t   cmd_b,
  arith_req_if.source        req
);
  import arith_pkg::*;

  alu_op_e op_mem [QUEUE_DEPTH];
  word_t   a_mem  [QUEUE_DEPTH];
  word_t   b_mem  [QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QPTR_W:0]   count;
  logic              push;
  logic              pop;

  assign cmd_ready = (count != (QPTR_W + 1)'(QUEUE_DEPTH));
  assign push      = cmd_valid && cmd_ready;
  assign pop       = req.valid && req.ready;

  // Oldest entry goes out first
  assign req.valid = (count != '0);
  assign req.op    = op_mem[rd_ptr];
  assign req.a     = a_mem[rd_ptr];
  assign req.b     = b_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count holds when both sides move
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= cmd_op;
      a_mem[wr_ptr]  <= cmd_a;
      b_mem[wr_ptr]  <= cmd_b;
    end
  end

endmodule

// File: rtl/alu_core.sv
`timescale 1ns/1ps

module alu_core (
  input  logic             clk,
  input  logic             reset,
  arith_req_if.sink        req,
  output logic             res_valid,
  input  logic             res_ready,
  output arith_pkg::word_t res_data,
  output logic             res_carry
);
  import arith_pkg::*;

  core_state_e state;
  core_state_e state_next;

  word_t add_a;
  word_t add_b;
  word_t add_sum;
  logic  add_cin;
  logic  add_cout;

  word_t result_q;
  logic  carry_q;
  word_t mcand_q;
  word_t mplier_q;

  logic [MUL_CNT_W-1:0] step_q;

  logic accept;
  logic sub_op;
  logic sub_ovf;
  logic lt_signed;
  logic lt_unsigned;

  assign req.ready = (state == ST_IDLE);
  assign accept    = req.valid && req.ready;

  // Everything but ADD runs a - b
  assign sub_op = (req.op != OP_ADD);

  ////////////////////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (state == ST_MUL) begin
      // Accumulator plus shifted multiplicand
      add_a   = result_q;
      add_b   = mcand_q;
      add_cin = 1'b0;
    end else begin
      add_a   = req.a;
      add_b   = sub_op ? ~req.b : req.b;
      add_cin = sub_op;
    end
  end

  prefix_adder #(
    .WIDTH (XLEN)
  ) i_adder (
    .a    (add_a),
    .b    (add_b),
    .cin  (add_cin),
    .sum  (add_sum),
    .cout (add_cout)
  );

  // Signed overflow of a - b when operand signs differ and the result sign flips
  assign sub_ovf     = (req.a[XLEN-1] != req.b[XLEN-1]) && (add_sum[XLEN-1] != req.a[XLEN-1]);
  assign lt_signed   = add_sum[XLEN-1] ^ sub_ovf;
  assign lt_unsigned = ~add_cout;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_next = (req.op == OP_MUL) ? ST_MUL : ST_DONE;
        end
      end
      ST_MUL: begin
        if (step_q == MUL_CNT_W'(XLEN - 1)) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        if (res_ready) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= ST_IDLE;
      step_q <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        step_q <= '0;
      end else if (state == ST_MUL) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      case (req.op)
        OP_SLT: begin
          result_q <= word_t'(lt_signed);
          carry_q  <= add_cout;
        end
        OP_SLTU: begin
          result_q <= word_t'(lt_unsigned);
          carry_q  <= add_cout;
        end
        OP_MUL: begin
          // Accumulator doubles as the result register
          result_q <= '0;
          carry_q  <= 1'b0;
          mcand_q  <= req.a;
          mplier_q <= req.b;
        end
        default: begin
          result_q <= add_sum;
          carry_q  <= add_cout;
        end
      endcase
    end else if (state == ST_MUL) begin
      if (mplier_q[0]) begin
        result_q <= add_sum;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Result held in ST_DONE until taken
  assign res_valid = (state == ST_DONE);
  assign res_data  = result_q;
  assign res_carry = carry_q;

endmodule

// File: rtl/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
  input  logic               clk,
  input  logic               reset,

  // Command port
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  arith_pkg::alu_op_e cmd_op,
  input  arith_pkg::word_t   cmd_a,
  input  arith_pkg::word_t   cmd_b,

  // Result port
  output logic               res_valid,
  input  logic               res_ready,
  output arith_pkg::word_t   res_data,
  output logic               res_carry
);

  arith_req_if req_if ();

  // Commands wait here in order
  op_queue i_queue (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .req       (req_if)
  );

  // One command at a time on the prefix adder
  alu_core i_core (
    .clk       (clk),
    .reset     (reset),
    .req       (req_if),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_carry (res_carry)
  );

endmodule

// File: dv/arith_unit_tb.sv
`timescale 1ns/1ps

module arith_unit_tb;
  import arith_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_RANDOM   = 200;
  // Upper bound on commands sent by all tests together
  localparam int NUM_CMDS     = 240;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * (XLEN + 8) + 200;

  localparam logic [15:0] LFSR_SEED = 16'd51712;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic    clk;
  logic    reset;
  logic    cmd_valid;
  logic    cmd_ready;
  alu_op_e cmd_op;
  word_t   cmd_a;
  word_t   cmd_b;
  logic    res_valid;
  logic    res_ready;
  word_t   res_data;
  logic    res_carry;

  // Expected results in command order
  word_t exp_data[$];
  logic  exp_carry[$];

  int          results_seen = 0;
  // 0 holds res_ready low, 1 holds it high, 2 toggles it randomly
  int          ready_mode = 1;
  logic [15:0] op_lfsr = LFSR_SEED;
  logic [15:0] rdy_lfsr = LFSR_SEED;

  arith_unit i_dut (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_carry (res_carry)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic check_carry(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, actual, expected));
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic word_t rand_word(input int nbits);
    word_t w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[XLEN-2:0], op_lfsr[0]};
      op_lfsr = lfsr_next(op_lfsr);
    end
    return w;
  endfunction

  // Expected result straight from the op definitions
  task automatic model_result(input alu_op_e op, input word_t a, input word_t b,
                              output word_t data, output logic carry);
    logic [XLEN:0]     wide;
    logic [2*XLEN-1:0] prod;
    wide  = {1'b0, a} + {1'b0, ~b} + (XLEN + 1)'(1);
    data  = '0;
    carry = wide[XLEN];
    case (op)
      OP_ADD: begin
        wide  = {1'b0, a} + {1'b0, b};
        data  = wide[XLEN-1:0];
        carry = wide[XLEN];
      end
      OP_SUB:  data = wide[XLEN-1:0];
      OP_SLT:  data = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      OP_SLTU: data = (a < b) ? word_t'(1) : word_t'(0);
      default: begin
        prod  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        data  = prod[XLEN-1:0];
        carry = 1'b0;
      end
    endcase
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_cmd(input alu_op_e op, input word_t a, input word_t b);
    word_t exp_d;
    logic  exp_c;
    model_result(op, a, b, exp_d, exp_c);
    exp_data.push_back(exp_d);
    exp_carry.push_back(exp_c);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_a     = a;
    cmd_b     = b;
    while (!cmd_ready) @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic drain_results();
    while (exp_data.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  // Sets res_ready for the coming edge and checks whatever transfers on it
  initial begin : result_monitor
    res_ready = 1'b0;
    forever begin
      @(negedge clk);
      case (ready_mode)
        0: res_ready = 1'b0;
        1: res_ready = 1'b1;
        default: begin
          res_ready = rdy_lfsr[0];
          rdy_lfsr  = lfsr_next(rdy_lfsr);
        end
      endcase
      if (!reset && res_valid && res_ready) begin
        if (exp_data.size() == 0) begin
          abort_run("A result came out with no command outstanding");
        end else begin
          check_data(res_data, exp_data.pop_front(),
                     $sformatf("res_data of result %0d", results_seen));
          check_carry(res_carry, exp_carry.pop_front(),
                      $sformatf("res_carry of result %0d", results_seen));
          results_seen++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("Watchdog timeout: the run hung before all results came back");
  end

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_carry(res_valid, 1'b0, "res_valid after reset");
    check_carry(cmd_ready, 1'b1, "cmd_ready after reset");
  endtask

  task automatic test_add_carry();
    ready_mode = 1;
    send_cmd(OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001);
    send_cmd(OP_ADD, 32'hAAAA_AAAA, 32'h5555_5555);
    send_cmd(OP_ADD, 32'hAAAA_AAAA, 32'hAAAA_AAAA);
    send_cmd(OP_ADD, 32'h5555_5555, 32'h5555_5555);
    send_cmd(OP_ADD, 32'h0000_0000, 32'h0000_0000);
    drain_results();
  endtask

  task automatic test_sub_compare();
    word_t a_list[5];
    word_t b_list[5];
    a_list = '{32'h1234_5678, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0005};
    b_list = '{32'h1234_5678, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFE};
    ready_mode = 1;
    for (int i = 0; i < 5; i++) begin
      send_cmd(OP_SUB, a_list[i], b_list[i]);
      send_cmd(OP_SLT, a_list[i], b_list[i]);
      send_cmd(OP_SLTU, a_list[i], b_list[i]);
    end
    drain_results();
  endtask

  task automatic test_mul();
    ready_mode = 1;
    send_cmd(OP_MUL, 32'h0000_0000, 32'h1234_5678);
    send_cmd(OP_MUL, 32'h0000_0001, 32'hDEAD_BEEF);
    send_cmd(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    send_cmd(OP_MUL, 32'hFFFF_FFFF, 32'h0000_0001);
    repeat (4) send_cmd(OP_MUL, rand_word(XLEN), rand_word(XLEN));
    drain_results();
  endtask

  task automatic test_backpressure();
    int accepted;
    accepted   = 0;
    ready_mode = 0;
    @(negedge clk);
    while (cmd_ready && accepted < 2 * QUEUE_DEPTH) begin
      send_cmd(alu_op_e'(3'(accepted % 5)), rand_word(XLEN), rand_word(XLEN));
      accepted++;
    end
    check_data(word_t'(accepted), word_t'(QUEUE_DEPTH + 1), "commands accepted before stall");
    // Nothing moves while the result is held
    repeat (XLEN + 4) @(negedge clk);
    check_carry(cmd_ready, 1'b0, "cmd_ready with queue full");
    check_carry(res_valid, 1'b1, "res_valid under back-pressure");
    ready_mode = 1;
    drain_results();
  endtask

  task automatic test_random_stream();
    alu_op_e op;
    ready_mode = 2;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op = alu_op_e'(3'(rand_word(3) % 5));
      send_cmd(op, rand_word(XLEN), rand_word(XLEN));
    end
    drain_results();
  endtask

  initial begin : main
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_ADD;
    cmd_a     = '0;
    cmd_b     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    test_reset();
    test_add_carry();
    test_sub_compare();
    test_mul();
    test_backpressure();
    test_random_stream();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: arith_unit.f
rtl/arith_pkg.sv
rtl/arith_req_if.sv
rtl/prefix_adder.sv
rtl/op_queue.sv
rtl/alu_core.sv
rtl/arith_unit.sv
dv/arith_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps
TOP       := arith_unit_tb
FILELIST  := arith_unit.f
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard rtl/*.sv dv/*.sv)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
